/* fp_misc_unit.f */
+incdir+sim
rtl/fp_misc_pkg.sv
rtl/fp_op_decode.sv
rtl/fp_issue_tracker.sv
rtl/fp_sign_inject.sv
rtl/fp_classify.sv
rtl/fp_compare.sv
rtl/fp_result_pack.sv
rtl/fp_misc_unit.sv
sim/tb_fp_misc_unit.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_fp_misc_unit
FILELIST   := fp_misc_unit.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
PASS_MSG   := Regression passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/fp_ref_model.svh */
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

function automatic logic ref_dbl(input fp_op_e op);
  case (op)
    op_fsgnj_d, op_fsgnjn_d, op_fsgnjx_d, op_fclass_d: return 1'b1;
    op_feq_d, op_flt_d, op_fle_d, op_fmin_d, op_fmax_d: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

function automatic logic ref_is_nan(input logic [63:0] x, input logic dbl);
  if (dbl) return (x[62:52] == 11'h7ff) && (x[51:0] != 0);
  return (x[30:23] == 8'hff) && (x[22:0] != 0);
endfunction

function automatic logic ref_is_snan(input logic [63:0] x, input logic dbl);
  return ref_is_nan(x, dbl) && !(dbl ? x[51] : x[22]);
endfunction

// Ordering key; both zeros map to zero
function automatic logic signed [64:0] ref_key(input logic [63:0] x, input logic dbl);
  logic signed [64:0] m;
  m = dbl ? {2'b0, x[62:0]} : {34'b0, x[30:0]};
  return (dbl ? x[63] : x[31]) ? -m : m;
endfunction

function automatic logic [9:0] ref_class(input logic [63:0] x, input logic dbl);
  logic s;
  logic e_all;
  logic e_zero;
  logic m_zero;
  int   idx;
  s      = dbl ? x[63] : x[31];
  e_all  = dbl ? (x[62:52] == 11'h7ff) : (x[30:23] == 8'hff);
  e_zero = dbl ? (x[62:52] == 0) : (x[30:23] == 0);
  m_zero = dbl ? (x[51:0] == 0) : (x[22:0] == 0);
  if (e_all && !m_zero) idx = (dbl ? x[51] : x[22]) ? 9 : 8;
  else if (e_all) idx = s ? 0 : 7;
  else if (e_zero && m_zero) idx = s ? 3 : 4;
  else if (e_zero) idx = s ? 2 : 5;
  else idx = s ? 1 : 6;
  return 10'b1 << idx;
endfunction

function automatic logic [63:0] ref_box(input logic [63:0] v, input logic dbl);
  return dbl ? v : {32'hffff_ffff, v[31:0]};
endfunction

// Distance from head, modulo the ROB size
function automatic logic ref_younger(input logic [4:0] tag, input logic [4:0] ftag,
                                     input logic [4:0] head);
  int da;
  int df;
  da = (int'(tag) - int'(head) + 32) % 32;
  df = (int'(ftag) - int'(head) + 32) % 32;
  return da > df;
endfunction

// Returns {flags, value}
function automatic logic [68:0] ref_result(input fp_op_e op, input logic [63:0] a,
                                           input logic [63:0] b);
  logic dbl;
  logic sa;
  logic sb;
  logic s;
  logic na;
  logic nb;
  logic nv;
  logic zz;
  logic signed [64:0] ka;
  logic signed [64:0] kb;
  logic [63:0] v;
  dbl = ref_dbl(op);
  sa  = dbl ? a[63] : a[31];
  sb  = dbl ? b[63] : b[31];
  na  = ref_is_nan(a, dbl);
  nb  = ref_is_nan(b, dbl);
  ka  = ref_key(a, dbl);
  kb  = ref_key(b, dbl);
  zz  = (ka == 0) && (kb == 0);
  nv  = 1'b0;
  v   = '0;
  case (op)
    op_fsgnj_s, op_fsgnj_d, op_fsgnjn_s, op_fsgnjn_d, op_fsgnjx_s, op_fsgnjx_d: begin
      if (op == op_fsgnj_s || op == op_fsgnj_d) s = sb;
      else if (op == op_fsgnjn_s || op == op_fsgnjn_d) s = !sb;
      else s = sa ^ sb;
      v = dbl ? {s, a[62:0]} : {32'hffff_ffff, s, a[30:0]};
    end
    op_fclass_s, op_fclass_d: v = {54'b0, ref_class(a, dbl)};
    op_feq_s, op_feq_d: begin
      v[0] = !na && !nb && (ka == kb);
      nv   = ref_is_snan(a, dbl) || ref_is_snan(b, dbl);
    end
    op_flt_s, op_flt_d: begin
      v[0] = !na && !nb && (ka < kb);
      nv   = na || nb;
    end
    op_fle_s, op_fle_d: begin
      v[0] = !na && !nb && (ka <= kb);
      nv   = na || nb;
    end
    default: begin
      // FMIN and FMAX
      if (na && nb) v = dbl ? 64'h7ff8_0000_0000_0000 : 64'h7fc0_0000;
      else if (na) v = b;
      else if (nb) v = a;
      else if (zz && (op == op_fmin_s || op == op_fmin_d)) v = sa ? a : b;
      else if (zz) v = sa ? b : a;
      else if (op == op_fmin_s || op == op_fmin_d) v = (ka < kb) ? a : b;
      else v = (ka > kb) ? a : b;
      v  = ref_box(v, dbl);
      nv = ref_is_snan(a, dbl) || ref_is_snan(b, dbl);
    end
  endcase
  return {nv, 4'b0, v};
endfunction

`endif

/* sim/tb_fp_misc_unit.sv */
`timescale 1ns/1ps

module tb_fp_misc_unit import fp_misc_pkg::*; ();

  `include "fp_ref_model.svh"

  logic             i_clk;
  logic             i_rst_n;
  issue_t           i_issue;
  complete_t        o_complete;
  logic             o_busy;
  logic             i_flush;
  logic             i_flush_en;
  logic [tag_w-1:0] i_flush_tag;
  logic [tag_w-1:0] i_rob_head_tag;

  // Expected completion of the op in flight
  logic             exp_valid;
  logic [tag_w-1:0] exp_tag;
  logic [63:0]      exp_value;
  logic [4:0]       exp_flags;
  string            cur_test;
  logic             started;
  logic [31:0]      lfsr_state;
  logic [tag_w-1:0] tag_ctr;
  logic             accepted;
  // Edges left in the expected busy window
  logic [1:0]       busy_cnt;

  fp_op_e ops [18] = '{op_fsgnj_s, op_fsgnjn_s, op_fsgnjx_s, op_fsgnj_d, op_fsgnjn_d,
                       op_fsgnjx_d, op_fclass_s, op_fclass_d, op_feq_s, op_flt_s,
                       op_fle_s, op_fmin_s, op_fmax_s, op_feq_d, op_flt_d, op_fle_d,
                       op_fmin_d, op_fmax_d};

  // Directed specials: +0, -0, +inf, -inf, subnormal, qNaN, sNaN, normal
  logic [31:0] spec_s [8] = '{32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, 32'hff80_0000,
                              32'h0000_0013, 32'h7fc0_0001, 32'hff80_0005, 32'hbf80_0000};
  logic [63:0] spec_d [8] = '{64'h0, 64'h8000_0000_0000_0000, 64'h7ff0_0000_0000_0000,
                              64'hfff0_0000_0000_0000, 64'h800f_0000_0000_0001,
                              64'hfff8_0000_0000_0002, 64'h7ff0_0000_0000_0009,
                              64'h3ff0_0000_0000_0000};

  fp_misc_unit dut (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_issue        (i_issue),
    .o_complete     (o_complete),
    .o_busy         (o_busy),
    .i_flush        (i_flush),
    .i_flush_en     (i_flush_en),
    .i_flush_tag    (i_flush_tag),
    .i_rob_head_tag (i_rob_head_tag)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // Issue taken at the coming rising edge when the unit is idle
  assign accepted = i_issue.valid & (busy_cnt == 2'd0) & (i_issue.op != op_illegal);

  // Busy from the edge after launch until three edges later
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy_cnt <= 2'd0;
    end else if (accepted) begin
      busy_cnt <= 2'd3;
    end else if (busy_cnt != 2'd0) begin
      busy_cnt <= busy_cnt - 2'd1;
    end
  end

  // ============================================================
  // Checking
  // ============================================================
  a_result: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $past(accepted, 2) |-> (o_complete.valid == exp_valid) &&
      (!exp_valid || ((o_complete.value == exp_value) && (o_complete.tag == exp_tag) &&
                      (o_complete.fp_flags == exp_flags))))
    else begin
      $display("Regression failed");
      $display("mismatch %s expected %0b/%0d/%h/%b actual %0b/%0d/%h/%b",
               cur_test, exp_valid, exp_tag, exp_value, exp_flags, o_complete.valid,
               o_complete.tag, o_complete.value, o_complete.fp_flags);
      $fatal(1);
    end

  // No completion without an accepted issue two edges back
  a_no_extra: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_complete.valid |-> $past(accepted, 2))
    else begin
      $display("Regression failed");
      $display("completion seen without an accepted issue in %s", cur_test);
      $fatal(1);
    end

  // Busy window of each launch
  a_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_busy == (busy_cnt != 2'd0))
    else begin
      $display("Regression failed");
      $display("mismatch %s busy expected %0b actual %0b",
               cur_test, busy_cnt != 2'd0, o_busy);
      $fatal(1);
    end

  a_idle_after_reset: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !started |-> !o_busy && !o_complete.valid)
    else begin
      $display("Regression failed");
      $display("busy or completion seen after reset before any issue");
      $fatal(1);
    end

  // ============================================================
  // Stimulus helpers
  // ============================================================
  task automatic timeout_fail(input string what);
    $display("Regression failed");
    $display("timeout waiting for %s in %s", what, cur_test);
    $fatal(1);
  endtask

  task automatic next_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
  endtask

  // Half specials, half random words
  task automatic pick_operand(input logic dbl, output logic [63:0] v);
    logic [63:0] r;
    next_bits(4, r);
    if (r[3]) begin
      next_bits(64, v);
    end else if (dbl) begin
      v = spec_d[r[2:0]];
    end else begin
      v = {32'hffff_ffff, spec_s[r[2:0]]};
    end
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    while (o_busy) begin
      @(negedge i_clk);
      t++;
      if (t > 20) timeout_fail("busy to clear");
    end
  endtask

  // Flush mode 0 none, 1 full in flight, 2 partial at launch,
  // 3 partial in flight, 4 full at launch
  task automatic issue_op(input fp_op_e op, input logic [63:0] a, input logic [63:0] b,
                          input string name, input int fmode,
                          input logic [4:0] ftag, input logic [4:0] head);
    logic [68:0] r;
    i_issue = '{valid: 1'b1, op: op, rob_tag: tag_ctr, src1: a, src2: b};
    // Held while busy, taken once busy drops
    wait_idle();
    r         = ref_result(op, a, b);
    exp_valid = 1'b1;
    exp_tag   = tag_ctr;
    exp_value = r[63:0];
    exp_flags = r[68:64];
    cur_test  = name;
    started   = 1'b1;
    if (fmode == 2) begin
      i_flush_en     = 1'b1;
      i_flush_tag    = ftag;
      i_rob_head_tag = head;
      exp_valid      = !ref_younger(tag_ctr, ftag, head);
    end else if (fmode == 4) begin
      i_flush   = 1'b1;
      exp_valid = 1'b0;
    end
    @(negedge i_clk);
    i_issue.valid = 1'b0;
    i_flush       = 1'b0;
    i_flush_en    = 1'b0;
    tag_ctr       = tag_ctr + 1'b1;
    if (fmode == 1) begin
      i_flush   = 1'b1;
      exp_valid = 1'b0;
      @(negedge i_clk);
      i_flush = 1'b0;
    end else if (fmode == 3) begin
      i_flush_en     = 1'b1;
      i_flush_tag    = ftag;
      i_rob_head_tag = head;
      exp_valid      = !ref_younger(exp_tag, ftag, head);
      @(negedge i_clk);
      i_flush_en = 1'b0;
    end
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    i_rst_n        = 1'b0;
    i_issue        = '0;
    i_issue.op     = op_illegal;
    i_flush        = 1'b0;
    i_flush_en     = 1'b0;
    i_flush_tag    = '0;
    i_rob_head_tag = '0;
    exp_valid      = 1'b0;
    exp_tag        = '0;
    exp_value      = '0;
    exp_flags      = '0;
    cur_test       = "reset";
    started        = 1'b0;
    lfsr_state     = 32'h25e035bb;
    tag_ctr        = '0;
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
    repeat (4) @(negedge i_clk);

    // Every op, back to back so each issue waits out busy
    foreach (ops[k]) begin
      for (int n = 0; n < 12; n++) begin
        pick_operand(ref_dbl(ops[k]), a);
        pick_operand(ref_dbl(ops[k]), b);
        next_bits(1, r);
        if (r[0] && n > 6) b = a;
        issue_op(ops[k], a, b, ops[k].name(), 0, 5'd0, 5'd0);
      end
    end

    // Illegal op never launches
    wait_idle();
    cur_test = "illegal";
    i_issue  = '{valid: 1'b1, op: op_illegal, rob_tag: 5'd3, src1: '0, src2: '0};
    repeat (4) @(negedge i_clk);
    i_issue.valid = 1'b0;

    // Full and partial flush, at launch and in flight, with wraparound
    wait_idle();
    issue_op(op_fsgnj_d, 64'h3ff0_0000_0000_0000, 64'h8000_0000_0000_0000,
             "full_flush", 1, 5'd0, 5'd0);
    wait_idle();
    issue_op(op_fclass_d, 64'h8000_0000_0000_0000, 64'h0,
             "full_flush_launch", 4, 5'd0, 5'd0);
    wait_idle();
    tag_ctr = 5'd1;
    issue_op(op_feq_s, 64'hffff_ffff_3f80_0000, 64'hffff_ffff_3f80_0000,
             "partial_younger_wrap", 2, 5'd31, 5'd30);
    wait_idle();
    tag_ctr = 5'd31;
    issue_op(op_fmax_d, 64'h4000_0000_0000_0000, 64'hc000_0000_0000_0000,
             "partial_older_wrap", 2, 5'd2, 5'd30);
    wait_idle();
    tag_ctr = 5'd9;
    issue_op(op_fclass_s, 64'hffff_ffff_ff80_0000, 64'h0,
             "partial_younger", 2, 5'd6, 5'd4);
    wait_idle();
    tag_ctr = 5'd7;
    issue_op(op_flt_d, 64'hbff0_0000_0000_0000, 64'h0,
             "partial_inflight_younger", 3, 5'd5, 5'd3);
    wait_idle();
    tag_ctr = 5'd30;
    issue_op(op_fsgnjx_s, 64'hffff_ffff_bf80_0000, 64'hffff_ffff_c000_0000,
             "partial_inflight_older_wrap", 3, 5'd1, 5'd28);
    wait_idle();
    repeat (4) @(negedge i_clk);
    $display("Regression passed");
    $finish;
  end

endmodule

/* rtl/fp_misc_unit.sv */
`timescale 1ns/1ps

module fp_misc_unit import fp_misc_pkg::*; (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  issue_t           i_issue,
  output complete_t        o_complete,
  output logic             o_busy,
  input  logic             i_flush,
  input  logic             i_flush_en,
  input  logic [tag_w-1:0] i_flush_tag,
  input  logic [tag_w-1:0] i_rob_head_tag
);

  unit_sel_e        unit;
  logic             is_double;
  logic             fire;
  logic             flushed;
  logic [tag_w-1:0] tag_q;
  fp_op_e           op_q;
  logic             dbl_q;
  logic             completing;
  unit_out_t        sgnj_out;
  unit_out_t        cls_out;
  unit_out_t        cmp_out;

  // Per-subunit launch pulses
  wire start_sgnj = fire & (unit == unit_sgnj);
  wire start_cls  = fire & (unit == unit_classify);
  wire start_cmp  = fire & (unit == unit_compare);

  fp_op_decode u_decode (
    .i_op        (i_issue.op),
    .o_unit      (unit),
    .o_is_double (is_double)
  );

  fp_issue_tracker u_tracker (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_issue        (i_issue),
    .i_unit         (unit),
    .i_is_double    (is_double),
    .i_completing   (completing),
    .i_flush        (i_flush),
    .i_flush_en     (i_flush_en),
    .i_flush_tag    (i_flush_tag),
    .i_rob_head_tag (i_rob_head_tag),
    .o_fire         (fire),
    .o_busy         (o_busy),
    .o_flushed      (flushed),
    .o_tag          (tag_q),
    .o_op           (op_q),
    .o_is_double    (dbl_q)
  );

  fp_sign_inject u_sgnj (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_start     (start_sgnj),
    .i_op        (i_issue.op),
    .i_is_double (is_double),
    .i_src1      (i_issue.src1),
    .i_src2      (i_issue.src2),
    .o_out       (sgnj_out)
  );

  fp_classify u_classify (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_start     (start_cls),
    .i_is_double (is_double),
    .i_src1      (i_issue.src1),
    .o_out       (cls_out)
  );

  fp_compare u_compare (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_start     (start_cmp),
    .i_op        (i_issue.op),
    .i_is_double (is_double),
    .i_src1      (i_issue.src1),
    .i_src2      (i_issue.src2),
    .o_out       (cmp_out)
  );

  fp_result_pack u_pack (
    .i_sgnj       (sgnj_out),
    .i_classify   (cls_out),
    .i_compare    (cmp_out),
    .i_op         (op_q),
    .i_is_double  (dbl_q),
    .i_tag        (tag_q),
    .i_flushed    (flushed),
    .o_complete   (o_complete),
    .o_completing (completing)
  );

endmodule

/* rtl/fp_result_pack.sv */
`timescale 1ns/1ps

module fp_result_pack import fp_misc_pkg::*; (
  input  unit_out_t        i_sgnj,
  input  unit_out_t        i_classify,
  input  unit_out_t        i_compare,
  input  fp_op_e           i_op,
  input  logic             i_is_double,
  input  logic [tag_w-1:0] i_tag,
  input  logic             i_flushed,
  output complete_t        o_complete,
  output logic             o_completing
);

  unit_out_t sel;
  logic      is_int;

  assign o_completing = i_sgnj.valid | i_classify.valid | i_compare.valid;

  // Finished subunit
  always_comb begin
    if (i_sgnj.valid) begin
      sel = i_sgnj;
    end else if (i_classify.valid) begin
      sel = i_classify;
    end else begin
      sel = i_compare;
    end
  end

  // Integer results go to the integer register file
  always_comb begin
    case (i_op)
      op_feq_s, op_flt_s, op_fle_s, op_fclass_s: is_int = 1'b1;
      op_feq_d, op_flt_d, op_fle_d, op_fclass_d: is_int = 1'b1;
      default:                                   is_int = 1'b0;
    endcase
  end

  always_comb begin
    o_complete.valid    = o_completing & ~i_flushed;
    o_complete.tag      = i_tag;
    o_complete.value    = '0;
    o_complete.fp_flags = '0;
    if (o_completing) begin
      o_complete.fp_flags = sel.flags;
      if (is_int) begin
        // Zero-extend
        o_complete.value = {{(flen - xlen){1'b0}}, sel.value[xlen-1:0]};
      end else if (i_is_double) begin
        o_complete.value = sel.value;
      end else begin
        // NaN-box single
        o_complete.value = {nan_box_upper, sel.value[31:0]};
      end
    end
  end

  // Single launch means a single finisher
  always_comb begin
    if (!$isunknown({i_sgnj.valid, i_classify.valid, i_compare.valid})) begin
      a_one_finisher: assert ($onehot0({i_sgnj.valid, i_classify.valid, i_compare.valid}));
    end
  end

endmodule

/* rtl/fp_compare.sv */
`timescale 1ns/1ps

module fp_compare import fp_misc_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_start,
  input  fp_op_e          i_op,
  input  logic            i_is_double,
  input  logic [flen-1:0] i_src1,
  input  logic [flen-1:0] i_src2,
  output unit_out_t       o_out
);

  logic            s1_valid;
  fp_op_e          s1_op;
  logic            s1_dbl;
  logic [flen-1:0] s1_a;
  logic [flen-1:0] s1_b;
  logic            out_valid;
  logic [flen-1:0] out_value;
  fp_flags_t       out_flags;
  fp_fields_t      fa;
  fp_fields_t      fb;
  logic            nan_a;
  logic            nan_b;
  logic            snan_any;
  logic            both_zero;
  logic            same;
  logic            lt_raw;
  logic [flen-1:0] canon;
  logic [flen-1:0] res;
  fp_flags_t       flg;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= i_start;
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      s1_op  <= i_op;
      s1_dbl <= i_is_double;
      s1_a   <= i_src1;
      s1_b   <= i_src2;
    end
  end

  // ==========================================================
  // Operand tests
  // ==========================================================
  assign fa        = fp_unpack(s1_a, s1_dbl);
  assign fb        = fp_unpack(s1_b, s1_dbl);
  assign nan_a     = fa.exp_max & ~fa.man_zero;
  assign nan_b     = fb.exp_max & ~fb.man_zero;
  assign snan_any  = (nan_a & ~fa.quiet) | (nan_b & ~fb.quiet);
  assign both_zero = ~|fa.mag & ~|fb.mag;
  assign same      = (fa.sign == fb.sign) && (fa.mag == fb.mag);
  assign canon     = s1_dbl ? canon_nan_d : {32'b0, canon_nan_s};

  // Sign-magnitude order, -0 below +0
  always_comb begin
    if (fa.sign != fb.sign) begin
      lt_raw = fa.sign;
    end else if (!fa.sign) begin
      lt_raw = fa.mag < fb.mag;
    end else begin
      lt_raw = fa.mag > fb.mag;
    end
  end

  // ==========================================================
  // Result select
  // ==========================================================
  always_comb begin
    res = '0;
    flg = '0;
    case (s1_op)
      op_feq_s, op_feq_d: begin
        // Quiet compare, only sNaN is invalid
        res[0] = ~nan_a & ~nan_b & (same | both_zero);
        flg.nv = snan_any;
      end
      op_flt_s, op_flt_d: begin
        res[0] = ~nan_a & ~nan_b & lt_raw & ~both_zero;
        flg.nv = nan_a | nan_b;
      end
      op_fle_s, op_fle_d: begin
        res[0] = ~nan_a & ~nan_b & (lt_raw | same | both_zero);
        flg.nv = nan_a | nan_b;
      end
      op_fmin_s, op_fmin_d, op_fmax_s, op_fmax_d: begin
        if (nan_a && nan_b) begin
          res = canon;
        end else if (nan_a) begin
          res = s1_b;
        end else if (nan_b) begin
          res = s1_a;
        end else if ((s1_op == op_fmin_s) || (s1_op == op_fmin_d)) begin
          res = lt_raw ? s1_a : s1_b;
        end else begin
          res = lt_raw ? s1_b : s1_a;
        end
        flg.nv = snan_any;
      end
      default: res = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (s1_valid) begin
      out_value <= res;
      out_flags <= flg;
    end
  end

  assign o_out = '{valid: out_valid, value: out_value, flags: out_flags};

endmodule

/* rtl/fp_classify.sv */
`timescale 1ns/1ps

module fp_classify import fp_misc_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_start,
  input  logic            i_is_double,
  input  logic [flen-1:0] i_src1,
  output unit_out_t       o_out
);

  logic            s1_valid;
  logic            s1_dbl;
  logic [flen-1:0] s1_a;
  logic            out_valid;
  logic [9:0]      out_class;
  fp_fields_t      f;
  logic [9:0]      cls;
  logic            pos;
  logic            neg;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= i_start;
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      s1_dbl <= i_is_double;
      s1_a   <= i_src1;
    end
  end

  assign f   = fp_unpack(s1_a, s1_dbl);
  assign neg = f.sign;
  assign pos = ~f.sign;

  // Standard FCLASS bit order
  always_comb begin
    cls    = '0;
    // Infinities
    cls[0] = neg & f.exp_max & f.man_zero;
    cls[7] = pos & f.exp_max & f.man_zero;
    // Normals
    cls[1] = neg & ~f.exp_max & ~f.exp_zero;
    cls[6] = pos & ~f.exp_max & ~f.exp_zero;
    // Subnormals
    cls[2] = neg & f.exp_zero & ~f.man_zero;
    cls[5] = pos & f.exp_zero & ~f.man_zero;
    // Signed zeros
    cls[3] = neg & f.exp_zero & f.man_zero;
    cls[4] = pos & f.exp_zero & f.man_zero;
    // NaNs ignore the sign
    cls[8] = f.exp_max & ~f.man_zero & ~f.quiet;
    cls[9] = f.exp_max & ~f.man_zero & f.quiet;
  end

  always_ff @(posedge i_clk) begin
    if (s1_valid) begin
      out_class <= cls;
    end
  end

  // Class mask in the low bits, rest zero
  assign o_out = '{valid: out_valid, value: {{(flen - 10){1'b0}}, out_class}, flags: '0};

  // Every operand falls in exactly one class
  a_class_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_out.valid |-> $onehot(o_out.value[9:0]));

endmodule

/* rtl/fp_sign_inject.sv */
`timescale 1ns/1ps

module fp_sign_inject import fp_misc_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_start,
  input  fp_op_e          i_op,
  input  logic            i_is_double,
  input  logic [flen-1:0] i_src1,
  input  logic [flen-1:0] i_src2,
  output unit_out_t       o_out
);

  // Stage 1 operand capture
  logic            s1_valid;
  fp_op_e          s1_op;
  logic            s1_dbl;
  logic [flen-1:0] s1_a;
  logic [flen-1:0] s1_b;
  // Stage 2 result
  logic            out_valid;
  logic [flen-1:0] out_value;
  logic            sign_a;
  logic            sign_b;
  logic            new_sign;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= i_start;
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      s1_op  <= i_op;
      s1_dbl <= i_is_double;
      s1_a   <= i_src1;
      s1_b   <= i_src2;
    end
  end

  assign sign_a = s1_dbl ? s1_a[63] : s1_a[31];
  assign sign_b = s1_dbl ? s1_b[63] : s1_b[31];

  // Sign source by variant
  always_comb begin
    case (s1_op)
      op_fsgnj_s, op_fsgnj_d:   new_sign = sign_b;
      op_fsgnjn_s, op_fsgnjn_d: new_sign = ~sign_b;
      op_fsgnjx_s, op_fsgnjx_d: new_sign = sign_a ^ sign_b;
      default:                  new_sign = sign_a;
    endcase
  end

  // Magnitude always from source 1
  always_ff @(posedge i_clk) begin
    if (s1_valid) begin
      out_value <= s1_dbl ? {new_sign, s1_a[62:0]} : {32'b0, new_sign, s1_a[30:0]};
    end
  end

  // Never raises an exception
  assign o_out = '{valid: out_valid, value: out_value, flags: '0};

endmodule

/* rtl/fp_issue_tracker.sv */
`timescale 1ns/1ps

module fp_issue_tracker import fp_misc_pkg::*; (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  issue_t           i_issue,
  input  unit_sel_e        i_unit,
  input  logic             i_is_double,
  input  logic             i_completing,
  input  logic             i_flush,
  input  logic             i_flush_en,
  input  logic [tag_w-1:0] i_flush_tag,
  input  logic [tag_w-1:0] i_rob_head_tag,
  output logic             o_fire,
  output logic             o_busy,
  output logic             o_flushed,
  output logic [tag_w-1:0] o_tag,
  output fp_op_e           o_op,
  output logic             o_is_double
);

  logic in_flight;
  // One extra busy cycle after completion
  logic drain;
  logic flush_inflight;
  logic flush_launching;

  assign o_busy = in_flight | drain;

  // Launch only a decodable op into an idle unit
  assign o_fire = i_issue.valid & (i_unit != unit_none) & ~o_busy;

  // Flush hits the op already in flight
  assign flush_inflight = in_flight &
      (i_flush | (i_flush_en & is_younger(o_tag, i_flush_tag, i_rob_head_tag)));
  // Flush hits the op launching this cycle
  assign flush_launching = o_fire &
      (i_flush | (i_flush_en & is_younger(i_issue.rob_tag, i_flush_tag, i_rob_head_tag)));

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      in_flight <= 1'b0;
      drain     <= 1'b0;
      o_flushed <= 1'b0;
    end else begin
      drain <= i_completing;
      if (i_completing) begin
        in_flight <= 1'b0;
        o_flushed <= 1'b0;
      end else begin
        if (o_fire) begin
          in_flight <= 1'b1;
        end
        if (flush_inflight || flush_launching) begin
          o_flushed <= 1'b1;
        end
      end
    end
  end

  // Tag, op and precision of the op in flight
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_tag       <= '0;
      o_op        <= op_illegal;
      o_is_double <= 1'b0;
    end else if (o_fire) begin
      o_tag       <= i_issue.rob_tag;
      o_op        <= i_issue.op;
      o_is_double <= i_is_double;
    end
  end

  // Subunit result lands exactly two edges after launch
  a_fire_to_complete: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_fire |-> ##2 i_completing);

  // Busy covers flight, completion and drain, so no second launch
  a_busy_window: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_fire |=> o_busy ##1 o_busy ##1 o_busy);

  // No stray subunit result
  a_complete_in_flight: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_completing |-> in_flight);

endmodule

/* rtl/fp_op_decode.sv */
`timescale 1ns/1ps

module fp_op_decode import fp_misc_pkg::*; (
  input  fp_op_e    i_op,
  output unit_sel_e o_unit,
  output logic      o_is_double
);

  // Pick the subunit and precision for the issued op
  always_comb begin
    o_unit      = unit_none;
    o_is_double = 1'b0;
    case (i_op)
      // Sign injection
      op_fsgnj_s, op_fsgnjn_s, op_fsgnjx_s: o_unit = unit_sgnj;
      op_fsgnj_d, op_fsgnjn_d, op_fsgnjx_d: begin
        o_unit      = unit_sgnj;
        o_is_double = 1'b1;
      end
      // Classification
      op_fclass_s: o_unit = unit_classify;
      op_fclass_d: begin
        o_unit      = unit_classify;
        o_is_double = 1'b1;
      end
      // Compare, min and max
      op_feq_s, op_flt_s, op_fle_s, op_fmin_s, op_fmax_s: o_unit = unit_compare;
      op_feq_d, op_flt_d, op_fle_d, op_fmin_d, op_fmax_d: begin
        o_unit      = unit_compare;
        o_is_double = 1'b1;
      end
      // Illegal ops never fire
      default: o_unit = unit_none;
    endcase
  end

endmodule

/* rtl/fp_misc_pkg.sv */
package fp_misc_pkg;

  // ==========================================================
  // Widths and constants
  // ==========================================================
  // FP register width
  localparam int flen = 64;
  // Integer register width
  localparam int xlen = 32;
  // ROB tag width
  localparam int tag_w = 5;

  // Upper half of a NaN-boxed single
  localparam logic [31:0] nan_box_upper = 32'hffff_ffff;
  // Canonical quiet NaNs
  localparam logic [31:0] canon_nan_s = 32'h7fc0_0000;
  localparam logic [63:0] canon_nan_d = 64'h7ff8_0000_0000_0000;

  // ==========================================================
  // Opcodes and unit select
  // ==========================================================
  typedef enum logic [4:0] {
    op_fsgnj_s,
    op_fsgnjn_s,
    op_fsgnjx_s,
    op_fsgnj_d,
    op_fsgnjn_d,
    op_fsgnjx_d,
    op_fclass_s,
    op_fclass_d,
    op_feq_s,
    op_flt_s,
    op_fle_s,
    op_fmin_s,
    op_fmax_s,
    op_feq_d,
    op_flt_d,
    op_fle_d,
    op_fmin_d,
    op_fmax_d,
    op_illegal = 5'd31
  } fp_op_e;

  typedef enum logic [1:0] {
    unit_none,
    unit_sgnj,
    unit_classify,
    unit_compare
  } unit_sel_e;

  // ==========================================================
  // Structs
  // ==========================================================
  // IEEE exception flags, fflags order
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_flags_t;

  // One issued instruction from the reservation station
  typedef struct packed {
    logic             valid;
    fp_op_e           op;
    logic [tag_w-1:0] rob_tag;
    logic [flen-1:0]  src1;
    logic [flen-1:0]  src2;
  } issue_t;

  // Completion towards the CDB adapter
  typedef struct packed {
    logic             valid;
    logic [tag_w-1:0] tag;
    logic [flen-1:0]  value;
    fp_flags_t        fp_flags;
  } complete_t;

  // Registered subunit output
  typedef struct packed {
    logic            valid;
    logic [flen-1:0] value;
    fp_flags_t       flags;
  } unit_out_t;

  // Operand fields, precision already resolved
  typedef struct packed {
    logic            sign;
    logic [flen-2:0] mag;
    logic            exp_max;
    logic            exp_zero;
    logic            man_zero;
    logic            quiet;
  } fp_fields_t;

  // ==========================================================
  // Helpers
  // ==========================================================
  // Split an operand into sign, magnitude and exponent/mantissa tests
  function automatic fp_fields_t fp_unpack(input logic [flen-1:0] v, input logic dbl);
    fp_fields_t f;
    if (dbl) begin
      f.sign     = v[63];
      f.mag      = v[62:0];
      f.exp_max  = &v[62:52];
      f.exp_zero = ~|v[62:52];
      f.man_zero = ~|v[51:0];
      f.quiet    = v[51];
    end else begin
      f.sign     = v[31];
      f.mag      = {32'b0, v[30:0]};
      f.exp_max  = &v[30:23];
      f.exp_zero = ~|v[30:23];
      f.man_zero = ~|v[22:0];
      f.quiet    = v[22];
    end
    return f;
  endfunction

  // Entry is younger when further from the ROB head than the flush tag
  function automatic logic is_younger(input logic [tag_w-1:0] entry_tag,
                                      input logic [tag_w-1:0] flush_tag,
                                      input logic [tag_w-1:0] head);
    logic [tag_w-1:0] entry_age;
    logic [tag_w-1:0] flush_age;
    // Modulo distance handles wraparound
    entry_age = entry_tag - head;
    flush_age = flush_tag - head;
    return entry_age > flush_age;
  endfunction

endpackage
